/* Bender.yml */
package:
  name: front_end

sources:
  - include_dirs:
      - hw
    files:
      - hw/bp_pkg.sv
      - hw/fe_pkg.sv
      - hw/bp_lookup_if.sv
      - hw/pattern_history_table.sv
      - hw/branch_predictor.sv
      - hw/fetch_pc_gen.sv
      - hw/front_end_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_front_end.sv

/* all.f */
+incdir+hw
hw/bp_pkg.sv
hw/fe_pkg.sv
hw/bp_lookup_if.sv
hw/pattern_history_table.sv
hw/branch_predictor.sv
hw/fetch_pc_gen.sv
hw/front_end_top.sv
tests/tb_clock_gen.sv
tests/tb_front_end.sv

/* hw/bp_consts.svh */
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// predictor table geometry
`define BP_ENTRIES 32
`define BP_IDX_W 5

// global history length, must be wider than the index
`define BP_GHR_W 7

// first fetch address, also the reset content of the btb
`define BP_RESET_PC 32'h4000_0000

`endif

/* hw/bp_lookup_if.sv */
`timescale 1ns/1ps

// one predictor lookup per unstalled cycle
interface bp_lookup_if;

    fe_pkg::hpc_t pc;            // address being fetched
    logic         is_branch;     // conditional branch at pc
    logic         is_jump;       // unconditional jump at pc
    logic         is_compressed; // 16-bit instruction at pc
    fe_pkg::hpc_t target;        // btb target for pc
    logic         taken;         // predicted direction for pc

    modport gen (
        output pc,
        output is_branch,
        output is_jump,
        output is_compressed,
        input  target,
        input  taken
    );

    modport pred (
        input  pc,
        input  is_branch,
        input  is_jump,
        input  is_compressed,
        output target,
        output taken
    );

endinterface

/* hw/bp_pkg.sv */
`include "bp_consts.svh"

package bp_pkg;

    // correction code issued from the execute stage
    typedef enum logic [1:0] {
        FIX_NONE            = 2'd0, // prediction held
        FIX_SHOULD_NOT_TAKE = 2'd1, // predicted taken, fell through
        FIX_SHOULD_TAKE     = 2'd2  // taken, but wrong direction or target
    } fix_e;

    // 2-bit saturating counter
    // 0 and 1 predict not taken, 2 and 3 predict taken
    typedef logic [1:0] ctr_t;

    // global history, newest outcome in bit 0
    typedef logic [`BP_GHR_W-1:0] ghr_t;

endpackage

/* hw/branch_predictor.sv */
`timescale 1ns/1ps

`include "bp_consts.svh"

module branch_predictor (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          stall_i,
    bp_lookup_if.pred     lk_o,
    // resolution from the execute stage
    input  logic          res_taken_i,
    input  fe_pkg::hpc_t  res_target_i,
    // recovery towards the pc generator
    output bp_pkg::fix_e  fix_o,
    output fe_pkg::hpc_t  exec_pc_o,
    output logic          exec_compressed_o
);

    localparam int DEC = 0;
    localparam int EXE = 1;

    localparam logic [31:0] RESET_PC = `BP_RESET_PC;

    // tables
    fe_pkg::hpc_t btb_q [`BP_ENTRIES];
    bp_pkg::ghr_t ghr_q;

    // per stage tracking, index DEC or EXE
    fe_pkg::hpc_t         pc_q   [2];
    logic [1:0]           vld_q;      // lookup flag
    logic [1:0]           jmp_q;
    logic [1:0]           cmp_q;      // compressed
    logic [1:0]           prd_q;      // predicted taken
    logic [`BP_IDX_W-1:0] idx_q  [2]; // counter index used at lookup
    bp_pkg::ghr_t         ckpt_q [2]; // history before the lookup shift

    logic                 is_cti;
    logic                 lookup;
    logic [`BP_IDX_W-1:0] btb_idx;
    logic [`BP_IDX_W-1:0] rd_idx;
    bp_pkg::ctr_t         rd_ctr;
    logic                 fix_active;
    logic                 pht_upd_en;
    logic                 target_ok;

    // lookup side
    assign is_cti  = lk_o.is_branch | lk_o.is_jump;
    assign lookup  = !stall_i && is_cti;
    assign btb_idx = lk_o.pc[`BP_IDX_W-1:0];
    assign rd_idx  = btb_idx ^ ghr_q[`BP_IDX_W-1:0]; // gshare

    assign lk_o.taken  = lk_o.is_jump | rd_ctr[1]; // jumps always taken
    assign lk_o.target = btb_q[btb_idx];

    pattern_history_table pht_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .rd_idx_i    (rd_idx),
        .rd_ctr_o    (rd_ctr),
        .upd_en_i    (pht_upd_en),
        .upd_idx_i   (idx_q[EXE]),
        .upd_taken_i (res_taken_i)
    );

    // decode stage holds the address fetched right after the branch
    assign target_ok = (pc_q[DEC] == res_target_i);

    always_comb begin
        fix_o = bp_pkg::FIX_NONE;
        if (!stall_i && vld_q[EXE]) begin
            if (prd_q[EXE] && res_taken_i && target_ok) begin
                fix_o = bp_pkg::FIX_NONE;
            end else if (prd_q[EXE] && !res_taken_i) begin
                fix_o = bp_pkg::FIX_SHOULD_NOT_TAKE;
            end else if (res_taken_i) begin
                fix_o = bp_pkg::FIX_SHOULD_TAKE; // direction or target wrong
            end
        end
    end

    assign fix_active = (fix_o != bp_pkg::FIX_NONE);
    assign pht_upd_en = !stall_i && vld_q[EXE] && !jmp_q[EXE]; // branches only

    assign exec_pc_o         = pc_q[EXE];
    assign exec_compressed_o = cmp_q[EXE];

    // lookup flags, squashed behind a correction
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vld_q <= '0;
        end else if (!stall_i) begin
            vld_q[DEC] <= is_cti && !fix_active;
            vld_q[EXE] <= vld_q[DEC] && !fix_active;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            pc_q[DEC]   <= lk_o.pc;
            jmp_q[DEC]  <= lk_o.is_jump;
            cmp_q[DEC]  <= lk_o.is_compressed;
            prd_q[DEC]  <= lk_o.taken;
            idx_q[DEC]  <= rd_idx;
            ckpt_q[DEC] <= ghr_q;

            pc_q[EXE]   <= pc_q[DEC];
            jmp_q[EXE]  <= jmp_q[DEC];
            cmp_q[EXE]  <= cmp_q[DEC];
            prd_q[EXE]  <= prd_q[DEC];
            idx_q[EXE]  <= idx_q[DEC];
            ckpt_q[EXE] <= ckpt_q[DEC];
        end
    end

    // global history
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ghr_q <= '0;
        end else if (fix_active) begin
            // back to the checkpoint, then the real outcome
            ghr_q <= {ckpt_q[EXE][`BP_GHR_W-2:0], res_taken_i};
        end else if (lookup) begin
            ghr_q <= {ghr_q[`BP_GHR_W-2:0], lk_o.taken}; // speculative
        end
    end

    // btb learns targets of taken branches it got wrong
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                btb_q[i] <= RESET_PC[31:1];
            end
        end else if (fix_o == bp_pkg::FIX_SHOULD_TAKE) begin
            btb_q[pc_q[EXE][`BP_IDX_W-1:0]] <= res_target_i;
        end
    end

endmodule

/* hw/fe_pkg.sv */
package fe_pkg;

    // fetch address with bit 0 dropped, holds address bits 31:1
    typedef logic [30:0] hpc_t;

    // instruction sizes counted in halfwords
    localparam hpc_t ILEN_HALF = 31'd1; // compressed
    localparam hpc_t ILEN_FULL = 31'd2; // 32-bit

endpackage

/* hw/fetch_pc_gen.sv */
`timescale 1ns/1ps

`include "bp_consts.svh"

module fetch_pc_gen (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          stall_i,
    // decode info for the address on fetch_pc_o
    input  logic          is_branch_i,
    input  logic          is_jump_i,
    input  logic          is_compressed_i,
    // recovery
    input  fe_pkg::hpc_t  res_target_i,
    input  bp_pkg::fix_e  fix_i,
    input  fe_pkg::hpc_t  exec_pc_i,
    input  logic          exec_compressed_i,
    bp_lookup_if.gen      lk_o,
    output fe_pkg::hpc_t  fetch_pc_o,
    output logic          pred_taken_o
);

    localparam logic [31:0] RESET_PC = `BP_RESET_PC;

    fe_pkg::hpc_t pc_q;
    fe_pkg::hpc_t pc_next;
    fe_pkg::hpc_t fetch_len;
    fe_pkg::hpc_t exec_len;
    fe_pkg::hpc_t seq_pc;
    fe_pkg::hpc_t rec_pc;

    // lookup runs off the current fetch address
    assign lk_o.pc            = pc_q;
    assign lk_o.is_branch     = is_branch_i;
    assign lk_o.is_jump       = is_jump_i;
    assign lk_o.is_compressed = is_compressed_i;

    assign pred_taken_o = lk_o.taken & (is_branch_i | is_jump_i);
    assign fetch_pc_o   = pc_q;

    assign fetch_len = is_compressed_i   ? fe_pkg::ILEN_HALF : fe_pkg::ILEN_FULL;
    assign exec_len  = exec_compressed_i ? fe_pkg::ILEN_HALF : fe_pkg::ILEN_FULL;
    assign seq_pc    = pc_q + fetch_len;
    assign rec_pc    = exec_pc_i + exec_len; // fall-through of the branch in execute

    // corrections first, then the prediction
    always_comb begin
        case (fix_i)
            bp_pkg::FIX_SHOULD_TAKE:     pc_next = res_target_i;
            bp_pkg::FIX_SHOULD_NOT_TAKE: pc_next = rec_pc;
            default: begin
                if (pred_taken_o) begin
                    pc_next = lk_o.target;
                end else begin
                    pc_next = seq_pc;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= RESET_PC[31:1];
        end else if (!stall_i) begin
            pc_q <= pc_next;
        end
    end

endmodule

/* hw/front_end_top.sv */
`timescale 1ns/1ps

module front_end_top (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        stall_i,
    // decode of the word at fetch_pc_o
    input  logic        is_branch_i,
    input  logic        is_jump_i,
    input  logic        is_compressed_i,
    // branch resolution, execute stage
    input  logic        res_taken_i,
    input  logic [31:0] res_target_i,
    output logic [31:0] fetch_pc_o,
    output logic        pred_taken_o,
    output logic [1:0]  fix_o
);

    bp_lookup_if lk ();

    fe_pkg::hpc_t fetch_hpc;
    fe_pkg::hpc_t res_target_hpc;
    fe_pkg::hpc_t exec_pc;
    logic         exec_compressed;
    bp_pkg::fix_e fix;

    // halfword addresses inside, byte addresses outside
    assign res_target_hpc = res_target_i[31:1];
    assign fetch_pc_o     = {fetch_hpc, 1'b0};
    assign fix_o          = fix;

    fetch_pc_gen pc_gen_i (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .stall_i           (stall_i),
        .is_branch_i       (is_branch_i),
        .is_jump_i         (is_jump_i),
        .is_compressed_i   (is_compressed_i),
        .res_target_i      (res_target_hpc),
        .fix_i             (fix),
        .exec_pc_i         (exec_pc),
        .exec_compressed_i (exec_compressed),
        .lk_o              (lk.gen),
        .fetch_pc_o        (fetch_hpc),
        .pred_taken_o      (pred_taken_o)
    );

    branch_predictor predictor_i (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .stall_i           (stall_i),
        .lk_o              (lk.pred),
        .res_taken_i       (res_taken_i),
        .res_target_i      (res_target_hpc),
        .fix_o             (fix),
        .exec_pc_o         (exec_pc),
        .exec_compressed_o (exec_compressed)
    );

endmodule

/* hw/pattern_history_table.sv */
`timescale 1ns/1ps

`include "bp_consts.svh"

module pattern_history_table (
    input  logic                 clk_i,
    input  logic                 rst_i,
    // read port
    input  logic [`BP_IDX_W-1:0] rd_idx_i,
    output bp_pkg::ctr_t         rd_ctr_o,
    // update port
    input  logic                 upd_en_i,
    input  logic [`BP_IDX_W-1:0] upd_idx_i,
    input  logic                 upd_taken_i
);

    bp_pkg::ctr_t ctr_q [`BP_ENTRIES];
    bp_pkg::ctr_t upd_ctr;
    bp_pkg::ctr_t upd_ctr_next;

    assign rd_ctr_o = ctr_q[rd_idx_i]; // combinational read
    assign upd_ctr  = ctr_q[upd_idx_i];

    // one step towards the outcome, saturating at both ends
    always_comb begin
        upd_ctr_next = upd_ctr;
        if (upd_taken_i) begin
            if (upd_ctr != 2'd3) begin
                upd_ctr_next = upd_ctr + 2'd1;
            end
        end else begin
            if (upd_ctr != 2'd0) begin
                upd_ctr_next = upd_ctr - 2'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                ctr_q[i] <= 2'd0; // strongly not taken
            end
        end else if (upd_en_i) begin
            ctr_q[upd_idx_i] <= upd_ctr_next;
        end
    end

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_o
);

    initial clk_o = 1'b0;
    always #(PERIOD / 2) clk_o = ~clk_o;

    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #2 rst_o = 1'b0; // released just after an edge
    end

endmodule

/* tests/tb_front_end.sv */
`timescale 1ns/1ps

`include "bp_consts.svh"

module tb_front_end;

    localparam logic [31:0] BASE = `BP_RESET_PC;
    localparam int LIMIT = 5 + 120 + 100 + 6 + 400 + 100; // stimulus cycles plus margin

    logic clk, gen_rst, tb_rst, rst, stall, is_branch, is_jump, is_compressed, res_taken;
    logic [31:0] res_target, fetch_pc;
    logic        pred_taken;
    logic [1:0]  fix;

    // program table, one slot per halfword
    int          kind [64]; // 0 plain, 1 branch, 2 jump
    logic        cmpz [64];
    logic [31:0] tgt  [64];
    int          mode [64]; // 1 always, 2 taken while cnt < limit, 3 random
    int          limit [64];
    int          cnt  [64];

    // reference model state
    logic [1:0]  m_pht [`BP_ENTRIES];
    logic [31:0] m_btb [`BP_ENTRIES];
    logic [`BP_GHR_W-1:0] m_ghr;
    logic [31:0] m_pc;
    logic [31:0] p_pc [2];
    logic [1:0]  p_vld, p_jmp, p_cmp, p_prd, p_rnd;
    logic [4:0]  p_idx [2];
    logic [`BP_GHR_W-1:0] p_ckpt [2];

    logic [1:0]  exp_fix;
    logic        exp_pred, cur_pt, cur_cti;
    logic [4:0]  cur_idx;
    logic [31:0] exp_next;

    integer seed = 32'h18cb_d5e9;
    int stall_pct, errors, checks, st_cnt, nt_cnt, cycle_cnt;

    assign rst = gen_rst | tb_rst;

    tb_clock_gen clock_i (.clk_o(clk), .rst_o(gen_rst));

    front_end_top front_end_top_i (
        .clk_i(clk), .rst_i(rst), .stall_i(stall),
        .is_branch_i(is_branch), .is_jump_i(is_jump), .is_compressed_i(is_compressed),
        .res_taken_i(res_taken), .res_target_i(res_target),
        .fetch_pc_o(fetch_pc), .pred_taken_o(pred_taken), .fix_o(fix)
    );

    function automatic int slot(logic [31:0] pc);
        return ((pc - BASE) >> 1) & 63;
    endfunction

    function automatic logic outcome(int s, logic rnd);
        if (kind[s] == 2) return 1'b1;
        if (kind[s] != 1) return 1'b0;
        if (mode[s] == 1) return 1'b1;
        if (mode[s] == 2) return cnt[s] < limit[s];
        return rnd;
    endfunction

    // correction rule of the execute stage
    function automatic logic [1:0] ref_fix(logic vld, logic prd, logic taken,
                                           logic [31:0] dec_pc, logic [31:0] target);
        if (!vld) return 2'd0;
        if (prd && taken && dec_pc == target) return 2'd0;
        if (prd && !taken) return 2'd1; // should not take
        if (taken) return 2'd2;         // should take
        return 2'd0;
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compute_expected();
        int s;
        s = slot(m_pc);
        cur_cti  = (kind[s] == 1) || (kind[s] == 2);
        cur_idx  = m_pc[5:1] ^ m_ghr[4:0];
        cur_pt   = (kind[s] == 2) | m_pht[cur_idx][1];
        exp_pred = cur_pt & cur_cti;
        exp_fix  = stall ? 2'd0 : ref_fix(p_vld[1], p_prd[1], res_taken, p_pc[0], res_target);
        if (exp_fix == 2'd2) exp_next = res_target;
        else if (exp_fix == 2'd1) exp_next = p_pc[1] + (p_cmp[1] ? 32'd2 : 32'd4);
        else if (exp_pred) exp_next = m_btb[m_pc[5:1]];
        else exp_next = m_pc + (cmpz[s] ? 32'd2 : 32'd4);
    endtask

    task automatic drive_inputs();
        int s, e;
        s = slot(m_pc);
        e = slot(p_pc[1]);
        is_branch     = kind[s] == 1;
        is_jump       = kind[s] == 2;
        is_compressed = cmpz[s];
        res_taken     = outcome(e, p_rnd[1]);
        res_target    = tgt[e];
        stall         = !rst && (($random(seed) & 32'h7fff_ffff) % 100) < stall_pct;
        compute_expected();
    endtask

    task automatic reset_model();
        for (int i = 0; i < `BP_ENTRIES; i++) begin
            m_pht[i] = 2'd0;
            m_btb[i] = BASE;
        end
        m_ghr = '0;
        m_pc  = BASE;
        p_vld = '0;
        for (int i = 0; i < 2; i++) begin
            p_pc[i] = BASE;
            p_idx[i] = '0;
            p_ckpt[i] = '0;
        end
    endtask

    task automatic advance_model();
        int e;
        logic fix_act;
        logic [`BP_GHR_W-1:0] next_ghr;
        e = slot(p_pc[1]);
        fix_act = exp_fix != 2'd0;
        if (p_vld[1] && !p_jmp[1]) begin
            if (res_taken && m_pht[p_idx[1]] != 2'd3) m_pht[p_idx[1]]++;
            if (!res_taken && m_pht[p_idx[1]] != 2'd0) m_pht[p_idx[1]]--;
            if (mode[e] == 2) cnt[e]++;
        end
        if (exp_fix == 2'd2) m_btb[p_pc[1][5:1]] = res_target;
        // history goes back to the execute checkpoint on a correction
        if (fix_act) next_ghr = {p_ckpt[1][`BP_GHR_W-2:0], res_taken};
        else if (cur_cti) next_ghr = {m_ghr[`BP_GHR_W-2:0], cur_pt};
        else next_ghr = m_ghr;
        // execute takes over decode, then decode takes the fetch
        p_pc[1]   = p_pc[0];
        p_jmp[1]  = p_jmp[0];
        p_cmp[1]  = p_cmp[0];
        p_prd[1]  = p_prd[0];
        p_idx[1]  = p_idx[0];
        p_ckpt[1] = p_ckpt[0];
        p_rnd[1]  = p_rnd[0];
        p_vld[1]  = p_vld[0] && !fix_act;
        p_pc[0]   = m_pc;
        p_jmp[0]  = kind[slot(m_pc)] == 2;
        p_cmp[0]  = cmpz[slot(m_pc)];
        p_prd[0]  = cur_pt;
        p_idx[0]  = cur_idx;
        p_ckpt[0] = m_ghr;
        p_rnd[0]  = $random(seed);
        p_vld[0]  = cur_cti && !fix_act;
        m_ghr = next_ghr;
        m_pc  = exp_next;
    endtask

    task automatic load_loop_program();
        for (int i = 0; i < 64; i++) begin
            kind[i]  = 0;
            cmpz[i]  = 1'b0;
            tgt[i]   = BASE;
            mode[i]  = 1;
            limit[i] = 0;
            cnt[i]   = 0;
        end
        cmpz[2]  = 1'b1;          // +4 compressed
        kind[5]  = 1;             // +10 loop branch back to +4
        mode[5]  = 2;
        limit[5] = 10;
        tgt[5]   = BASE + 32'd4;
        cmpz[7]  = 1'b1;          // +14 compressed
        kind[8]  = 1;             // +16 always taken
        tgt[8]   = BASE + 32'd24;
        kind[12] = 2;             // +24 jump back
        cmpz[12] = 1'b1;
    endtask

    task automatic load_random_program();
        int r;
        for (int i = 0; i < 64; i++) begin
            r = ($random(seed) & 32'h7fff_ffff) % 10;
            kind[i] = (r < 6) ? 0 : (r < 9) ? 1 : 2;
            cmpz[i] = $random(seed);
            tgt[i]  = BASE + 32'd2 * (($random(seed) & 32'h7fff_ffff) % 64);
            mode[i] = 3;
            cnt[i]  = 0;
        end
    endtask

    task automatic run_test(string name, int pct, int cycles);
        int err0;
        err0 = errors;
        st_cnt = 0;
        nt_cnt = 0;
        stall_pct = pct;
        repeat (cycles) @(posedge clk);
        stall_pct = 0;
        if (name == "loop_training") begin
            check_val("should_take_seen", st_cnt != 0, 1);
            check_val("should_not_take_seen", nt_cnt != 0, 1);
        end
        $display("test %s done, %0d errors", name, errors - err0);
    endtask

    always @(posedge clk) begin
        if (rst) reset_model();
        else if (!stall) advance_model();
        #2 drive_inputs();
    end

    always @(negedge clk) begin
        if (!rst) begin
            check_val("fetch_pc_o", fetch_pc, m_pc);
            check_val("pred_taken_o", pred_taken, exp_pred);
            check_val("fix_o", fix, exp_fix);
            if (fix == 2'd1) nt_cnt++; // corrections seen on the port
            if (fix == 2'd2) st_cnt++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        {stall, is_branch, is_jump, is_compressed, res_taken} = '0;
        res_target = BASE;
        tb_rst = 1'b0;
        stall_pct = 0;
        errors = 0;
        checks = 0;
        cycle_cnt = 0;
        load_loop_program();
        reset_model();
        @(negedge gen_rst);
        @(negedge clk);
        check_val("fetch_pc_o after reset", fetch_pc, BASE);
        run_test("loop_training", 0, 120);
        run_test("stall_hold", 30, 100);
        @(posedge clk);
        #2 tb_rst = 1'b1;
        #1 load_random_program();
        repeat (5) @(posedge clk);
        #2 tb_rst = 1'b0;
        run_test("random_mix", 15, 400);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
